// File: distram512d.sv
`timescale 1ns/1ps

module distram512d #(
    parameter int WIDTH = 3
) (
    input  logic             clk,

    // write port
    input  logic [8:0]       a_addr,
    input  logic [WIDTH-1:0] a_wrdata,
    input  logic             a_wren,

    // asynchronous read port
    input  logic [8:0]       b_addr,
    output logic [WIDTH-1:0] b_rddata
);

    localparam int DEPTH = 512;

    logic [WIDTH-1:0] mem [DEPTH];

    // contents come up cleared at configuration
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (a_wren) begin
            mem[a_addr] <= a_wrdata;
        end
    end

    assign b_rddata = mem[b_addr];

endmodule

// File: files.f
gfx_pkg.sv
render_if.sv
distram512d.sv
renderer.sv
job_queue.sv
render_sequencer.sv
line_buffer.sv
line_render_top.sv
tb_line_render.sv

// File: gfx_pkg.sv
package gfx_pkg;

    // line geometry
    localparam int LINE_IDX_W      = 9;
    localparam int PIXELS_PER_WORD = 8;

    // pixel and attribute field widths
    localparam int COLOUR_W  = 4;
    localparam int PALETTE_W = 3;
    localparam int ZDEPTH_W  = 3;

    // line buffer entry, palette in the upper bits and colour in the lower
    typedef logic [PALETTE_W+COLOUR_W-1:0] pixel_t;

    // one render job as queued by the host
    typedef struct packed {
        logic [LINE_IDX_W-1:0]               idx;
        logic [PIXELS_PER_WORD*COLOUR_W-1:0] data;
        logic                                hflip;
        logic [PALETTE_W-1:0]                palette;
        logic [ZDEPTH_W-1:0]                 zdepth;
        logic                                zdepth_init;
    } render_job_t;

    // sequencer states
    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

endpackage

// File: job_queue.sv
`timescale 1ns/1ps

module job_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    // host side
    input  logic                 wr,
    input  gfx_pkg::render_job_t wr_job,
    output logic                 full,

    // sequencer side
    output gfx_pkg::render_job_t head,
    output logic                 empty,
    input  logic                 pop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    gfx_pkg::render_job_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // writes into a full queue are lost
    assign do_push = wr && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_job;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(QUEUE_DEPTH));

    a_not_empty_and_full: assert property (@(posedge clk) disable iff (reset) !(empty && full));

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic                           clk,
    input  logic                           reset,

    // renderer write port
    input  logic [gfx_pkg::LINE_IDX_W-1:0] wridx,
    input  gfx_pkg::pixel_t                wrdata,
    input  logic                           wren,

    // display scanout
    input  logic                           rd_en,
    input  logic [gfx_pkg::LINE_IDX_W-1:0] rd_idx,
    output gfx_pkg::pixel_t                rd_data
);

    localparam int DEPTH = 2 ** gfx_pkg::LINE_IDX_W;

    gfx_pkg::pixel_t mem [DEPTH];

    // line starts blank at configuration
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // clear on read, a write to the same entry lands last and wins
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem[rd_idx] <= '0;
        end
        if (wren) begin
            mem[wridx] <= wrdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// File: line_render_top.sv
`timescale 1ns/1ps

module line_render_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                reset,

    // host job port
    input  logic                                                job_wr,
    input  logic [gfx_pkg::LINE_IDX_W-1:0]                      job_idx,
    input  logic [gfx_pkg::PIXELS_PER_WORD*gfx_pkg::COLOUR_W-1:0] job_data,
    input  logic                                                job_hflip,
    input  logic [gfx_pkg::PALETTE_W-1:0]                       job_palette,
    input  logic [gfx_pkg::ZDEPTH_W-1:0]                        job_zdepth,
    input  logic                                                job_zdepth_init,
    output logic                                                job_full,
    output logic                                                idle,

    // display scanout
    input  logic                                                rd_en,
    input  logic [gfx_pkg::LINE_IDX_W-1:0]                      rd_idx,
    output gfx_pkg::pixel_t                                     rd_data
);

    gfx_pkg::render_job_t            wr_job;
    gfx_pkg::render_job_t            head_job;
    logic                            queue_empty;
    logic                            queue_pop;
    logic                            seq_active;
    logic [gfx_pkg::LINE_IDX_W-1:0]  wridx;
    gfx_pkg::pixel_t                 wrdata;
    logic                            wren;

    render_if rif ();

    assign wr_job.idx         = job_idx;
    assign wr_job.data        = job_data;
    assign wr_job.hflip       = job_hflip;
    assign wr_job.palette     = job_palette;
    assign wr_job.zdepth      = job_zdepth;
    assign wr_job.zdepth_init = job_zdepth_init;

    // nothing queued, nothing being handed over, nothing being drawn
    assign idle = queue_empty && !seq_active && !rif.busy;

    job_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) job_queue_i (
        .clk(clk), .reset(reset),
        .wr(job_wr), .wr_job(wr_job), .full(job_full),
        .head(head_job), .empty(queue_empty), .pop(queue_pop)
    );

    render_sequencer render_sequencer_i (
        .clk(clk), .reset(reset),
        .head(head_job), .empty(queue_empty), .pop(queue_pop),
        .active(seq_active), .rif(rif.seq)
    );

    renderer renderer_i (
        .clk(clk), .reset(reset), .rif(rif.rend),
        .wridx(wridx), .wrdata(wrdata), .wren(wren)
    );

    line_buffer line_buffer_i (
        .clk(clk), .reset(reset),
        .wridx(wridx), .wrdata(wrdata), .wren(wren),
        .rd_en(rd_en), .rd_idx(rd_idx), .rd_data(rd_data)
    );

endmodule

// File: render_if.sv
`timescale 1ns/1ps

// job handoff between the sequencer and the renderer
interface render_if;

    // job word, held stable while the renderer works on it
    gfx_pkg::render_job_t job;

    // single-cycle request to begin a job
    logic start;

    // high for the eight write cycles of a job
    logic busy;

    // marks the cycle of the eighth write
    logic last_pixel;

    modport seq (
        output job,
        output start,
        input  busy,
        input  last_pixel
    );

    modport rend (
        input  job,
        input  start,
        output busy,
        output last_pixel
    );

endinterface

// File: render_sequencer.sv
`timescale 1ns/1ps

module render_sequencer (
    input  logic                 clk,
    input  logic                 reset,

    // queue side
    input  gfx_pkg::render_job_t head,
    input  logic                 empty,
    output logic                 pop,

    // high whenever a job is in flight
    output logic                 active,

    render_if.seq                rif
);

    gfx_pkg::seq_state_e  state, state_next;
    gfx_pkg::render_job_t job_q;
    logic                 start_q;

    always_comb begin
        state_next = state;
        pop        = 1'b0;

        case (state)
            gfx_pkg::SEQ_IDLE: begin
                if (!empty) begin
                    pop        = 1'b1;
                    state_next = gfx_pkg::SEQ_RUN;
                end
            end
            gfx_pkg::SEQ_RUN: begin
                // chain the next job off the final pixel of the current one
                if (rif.last_pixel && !empty) begin
                    pop = 1'b1;
                end else if (!rif.busy && !start_q) begin
                    state_next = gfx_pkg::SEQ_IDLE;
                end
            end
            default: state_next = gfx_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= gfx_pkg::SEQ_IDLE;
            start_q <= 1'b0;
        end else begin
            state   <= state_next;
            start_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            job_q <= head;
        end
    end

    assign rif.job   = job_q;
    assign rif.start = start_q;
    assign active    = (state == gfx_pkg::SEQ_RUN);

    a_start_single: assert property (@(posedge clk) disable iff (reset) start_q |=> !start_q);

endmodule

// File: renderer.sv
`timescale 1ns/1ps

module renderer (
    input  logic                            clk,
    input  logic                            reset,

    render_if.rend                          rif,

    // line buffer write port
    output logic [gfx_pkg::LINE_IDX_W-1:0]  wridx,
    output gfx_pkg::pixel_t                 wrdata,
    output logic                            wren
);

    localparam int SLOT_W   = $clog2(gfx_pkg::PIXELS_PER_WORD);
    localparam int DATA_W   = gfx_pkg::PIXELS_PER_WORD * gfx_pkg::COLOUR_W;
    localparam int COLOUR_W = gfx_pkg::COLOUR_W;
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(gfx_pkg::PIXELS_PER_WORD - 1);

    // job payload
    logic [DATA_W-1:0]                d_data,      q_data;
    logic [gfx_pkg::PALETTE_W-1:0]    d_palette,   q_palette;
    logic [gfx_pkg::ZDEPTH_W-1:0]     d_zdepth,    q_zdepth;
    logic                             d_zinit,     q_zinit;
    logic                             d_hflip,     q_hflip;
    logic [gfx_pkg::LINE_IDX_W-1:0]   d_wridx,     q_wridx;
    gfx_pkg::pixel_t                  d_wrdata,    q_wrdata;

    // control
    logic [SLOT_W-1:0]                d_slot,      q_slot;
    logic                             d_busy,      q_busy;
    logic                             d_wren,      q_wren;
    logic                             d_last,      q_last;

    logic [COLOUR_W-1:0]              colour;
    logic [gfx_pkg::ZDEPTH_W-1:0]     cur_zdepth;
    logic [gfx_pkg::ZDEPTH_W-1:0]     new_zdepth;

    // slot k takes nibble k from the top, or nibble 7-k when flipped
    function automatic logic [COLOUR_W-1:0] nibble_at(
        input logic [DATA_W-1:0] data,
        input logic [SLOT_W-1:0] slot,
        input logic              hflip
    );
        logic [SLOT_W-1:0] lsb_slot;
        lsb_slot = hflip ? slot : LAST_SLOT - slot;
        return data[lsb_slot*COLOUR_W +: COLOUR_W];
    endfunction

    assign wridx          = q_wridx;
    assign wrdata         = q_wrdata;
    assign wren           = q_wren;
    assign rif.busy       = q_busy;
    assign rif.last_pixel = q_last;

    // address of the next write, also used to look up the stored depth
    always_comb begin
        if (rif.start) begin
            d_wridx = rif.job.idx;
        end else if (q_busy) begin
            d_wridx = q_wridx + 1'b1;
        end else begin
            d_wridx = q_wridx;
        end
    end

    // transparent pixels clear the depth so anything may draw over them
    assign new_zdepth = (q_wrdata[COLOUR_W-1:0] == '0) ? '0 : q_zdepth;

    distram512d #(
        .WIDTH    (gfx_pkg::ZDEPTH_W)
    ) zbuf_i (
        .clk      (clk),
        .a_addr   (q_wridx),
        .a_wrdata (new_zdepth),
        .a_wren   (q_wren),
        .b_addr   (d_wridx),
        .b_rddata (cur_zdepth)
    );

    always_comb begin
        d_data    = q_data;
        d_palette = q_palette;
        d_zdepth  = q_zdepth;
        d_zinit   = q_zinit;
        d_hflip   = q_hflip;
        d_slot    = q_slot;
        d_busy    = q_busy;
        d_wren    = 1'b0;
        d_last    = 1'b0;

        if (rif.start) begin
            d_data    = rif.job.data;
            d_palette = rif.job.palette;
            d_zdepth  = rif.job.zdepth;
            d_zinit   = rif.job.zdepth_init;
            d_hflip   = rif.job.hflip;
            d_slot    = '0;
            d_busy    = 1'b1;
            d_wren    = 1'b1;
        end else if (q_busy) begin
            d_slot = q_slot + 1'b1;
            d_wren = 1'b1;
            if (q_slot == LAST_SLOT) begin
                d_busy = 1'b0;
                d_wren = 1'b0;
            end
            if (q_slot == LAST_SLOT - 1'b1) begin
                d_last = 1'b1;
            end
        end

        colour   = nibble_at(d_data, d_slot, d_hflip);
        d_wrdata = {d_palette, colour};

        // skip transparent pixels and pixels behind what is already there
        if (!d_zinit && (colour == '0 || d_zdepth < cur_zdepth)) begin
            d_wren = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_slot <= '0;
            q_busy <= 1'b0;
            q_wren <= 1'b0;
            q_last <= 1'b0;
        end else begin
            q_slot <= d_slot;
            q_busy <= d_busy;
            q_wren <= d_wren;
            q_last <= d_last;
        end
    end

    always_ff @(posedge clk) begin
        q_data    <= d_data;
        q_palette <= d_palette;
        q_zdepth  <= d_zdepth;
        q_zinit   <= d_zinit;
        q_hflip   <= d_hflip;
        q_wridx   <= d_wridx;
        q_wrdata  <= d_wrdata;
    end

    a_wren_in_job: assert property (@(posedge clk) disable iff (reset) q_wren |-> q_busy);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_line_render \
    -f files.f \
    -o sim_line_render

status=0
./obj_dir/sim_line_render > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb_line_render.sv
`timescale 1ns/1ps

module tb_line_render;

    localparam int QUEUE_DEPTH     = 4;
    localparam int LINE_LEN        = 512;
    localparam int NUM_JOBS        = 14;
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * 20 + 2 * LINE_LEN;

    logic                                                clk;
    logic                                                reset;
    logic                                                job_wr;
    logic [gfx_pkg::LINE_IDX_W-1:0]                      job_idx;
    logic [gfx_pkg::PIXELS_PER_WORD*gfx_pkg::COLOUR_W-1:0] job_data;
    logic                                                job_hflip;
    logic [gfx_pkg::PALETTE_W-1:0]                       job_palette;
    logic [gfx_pkg::ZDEPTH_W-1:0]                        job_zdepth;
    logic                                                job_zdepth_init;
    logic                                                job_full;
    logic                                                idle;
    logic                                                rd_en;
    logic [gfx_pkg::LINE_IDX_W-1:0]                      rd_idx;
    gfx_pkg::pixel_t                                     rd_data;

    // job table and the expected line contents
    gfx_pkg::render_job_t         jobs [NUM_JOBS];
    gfx_pkg::pixel_t              exp_pix [LINE_LEN];
    logic [gfx_pkg::ZDEPTH_W-1:0] exp_z [LINE_LEN];

    int seed;
    int errors;

    line_render_top #(
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) line_render_top_i (
        .clk             (clk),
        .reset           (reset),
        .job_wr          (job_wr),
        .job_idx         (job_idx),
        .job_data        (job_data),
        .job_hflip       (job_hflip),
        .job_palette     (job_palette),
        .job_zdepth      (job_zdepth),
        .job_zdepth_init (job_zdepth_init),
        .job_full        (job_full),
        .idle            (idle),
        .rd_en           (rd_en),
        .rd_idx          (rd_idx),
        .rd_data         (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic set_job(input int n, input int idx, input logic [31:0] data,
                           input int hflip, input int pal, input int z, input int zinit);
        jobs[n].idx         = 9'(idx);
        jobs[n].data        = data;
        jobs[n].hflip       = 1'(hflip);
        jobs[n].palette     = 3'(pal);
        jobs[n].zdepth      = 3'(z);
        jobs[n].zdepth_init = 1'(zinit);
    endtask

    task automatic build_table();
        logic [31:0] word;
        // opaque word, then the same word flipped
        set_job(0, 10, 32'h1234_5678, 0, 3, 2, 1);
        set_job(1, 30, 32'h1234_5678, 1, 5, 2, 1);
        // base row, then a word with holes drawn over it
        set_job(2, 50, 32'h9abc_def1, 0, 1, 1, 1);
        set_job(3, 50, 32'h2030_4050, 0, 6, 4, 0);
        // depth overlap: deep base, lower job behind it, equal job over it
        set_job(4, 70, 32'hffff_ffff, 0, 2, 5, 1);
        set_job(5, 66, 32'h7777_7777, 0, 4, 3, 0);
        set_job(6, 72, 32'h8888_8888, 0, 7, 5, 0);
        // wraps past the end of the line
        word = $random(seed);
        set_job(7, 508, word, 0, 3, 1, 1);
        // burst of overlapping random words, longer than the queue
        for (int k = 0; k < 6; k++) begin
            word = $random(seed);
            set_job(8 + k, 200 + 6 * k, word, k % 2, (k + 1) % 8, 3 - (k % 3),
                    (k % 3 == 0) ? 1 : 0);
        end
    endtask

    // reference model of one job against the expected line and depth
    task automatic apply_job(input gfx_pkg::render_job_t job);
        int         src;
        logic [8:0] pos;
        logic [3:0] colour;
        for (int k = 0; k < gfx_pkg::PIXELS_PER_WORD; k++) begin
            src    = job.hflip ? 7 - k : k;
            colour = job.data[31 - 4 * src -: 4];
            pos    = 9'(int'(job.idx) + k);
            if (job.zdepth_init || (colour != 4'h0 && job.zdepth >= exp_z[pos])) begin
                exp_pix[pos] = {job.palette, colour};
                exp_z[pos]   = (colour == 4'h0) ? 3'd0 : job.zdepth;
            end
        end
    endtask

    task automatic push_job(input gfx_pkg::render_job_t job);
        @(negedge clk);
        while (job_full) begin
            @(negedge clk);
        end
        @(posedge clk);
        job_wr          <= 1'b1;
        job_idx         <= job.idx;
        job_data        <= job.data;
        job_hflip       <= job.hflip;
        job_palette     <= job.palette;
        job_zdepth      <= job.zdepth;
        job_zdepth_init <= job.zdepth_init;
        @(posedge clk);
        job_wr <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
    endtask

    task automatic check_pixel(input int pos, input gfx_pkg::pixel_t want);
        assert (rd_data === want) else begin
            errors++;
            $display("MISMATCH at %0t ns: rd_data[%0d] got %h expected %h",
                     $time, pos, rd_data, want);
        end
    endtask

    // read data trails the address by one cycle
    task automatic scan_line(input bit expect_blank);
        gfx_pkg::pixel_t want;
        for (int i = 0; i <= LINE_LEN; i++) begin
            @(posedge clk);
            if (i < LINE_LEN) begin
                rd_en  <= 1'b1;
                rd_idx <= 9'(i);
            end else begin
                rd_en <= 1'b0;
            end
            if (i > 0) begin
                @(negedge clk);
                want = expect_blank ? 7'h00 : exp_pix[i - 1];
                check_pixel(i - 1, want);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: rendering and scanout did not finish in %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        job_wr          = 1'b0;
        job_idx         = '0;
        job_data        = '0;
        job_hflip       = 1'b0;
        job_palette     = '0;
        job_zdepth      = '0;
        job_zdepth_init = 1'b0;
        rd_en           = 1'b0;
        rd_idx          = '0;
        seed            = 33;
        errors          = 0;

        for (int i = 0; i < LINE_LEN; i++) begin
            exp_pix[i] = '0;
            exp_z[i]   = '0;
        end
        build_table();
        for (int n = 0; n < NUM_JOBS; n++) begin
            apply_job(jobs[n]);
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        assert (idle === 1'b1 && job_full === 1'b0) else begin
            errors++;
            $display("after reset the DUT is not idle or reports a full queue");
        end
        check_pixel(0, 7'h00);

        for (int n = 0; n < NUM_JOBS; n++) begin
            push_job(jobs[n]);
        end
        wait_idle();

        scan_line(1'b0);
        // every entry was cleared by the first pass
        scan_line(1'b1);

        $display("line render checks finished with %0d errors over %0d reads",
                 errors, 2 * LINE_LEN);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
